/* logic/wb_master_pkg.sv */
// bus widths, burst length, select constant, sequencer state enum and request source enum
package wb_master_pkg;

    // ========================================
    // bus geometry
    // ========================================

    // one wishbone word, also the width of cache read and write data
    parameter int WB_DATA_W = 32;

    // one select line per byte lane
    parameter int WB_SEL_W = WB_DATA_W / 8;

    // a cache line fill is four words, so address bits [3:2] wrap
    parameter int BURST_BEATS = 4;
    parameter int BEAT_W = $clog2(BURST_BEATS);

    // reads always fetch the whole word
    parameter logic [WB_SEL_W-1:0] FULL_SEL = '1;

    // ========================================
    // encodings
    // ========================================

    // posted writes never leave WB_IDLE
    // single reads go straight to WB_WAIT_ACK
    // line fills walk through the three burst states first
    typedef enum logic [2:0] {
        WB_IDLE     = 3'd0,
        WB_BURST1   = 3'd1,
        WB_BURST2   = 3'd2,
        WB_BURST3   = 3'd3,
        WB_WAIT_ACK = 3'd4
    } wb_state_e;

    // granted requester, which also selects the kind of access
    typedef enum logic [1:0] {
        SRC_NONE            = 2'd0,
        SRC_DCACHE_CACHED   = 2'd1,
        SRC_DCACHE_UNCACHED = 2'd2,
        SRC_ICACHE          = 2'd3
    } req_src_e;

endpackage

/* logic/wb_req_if.sv */
// granted request from the arbiter to the bus sequencer, with progress signals back
interface wb_req_if #(
    parameter int ADDR_W = 32
);
    import wb_master_pkg::*;

    // request side, driven by the arbiter
    logic                 valid;
    req_src_e             src;
    logic                 write;
    logic                 qword;
    logic                 exclusive;
    logic [ADDR_W-1:0]    adr;
    logic [WB_SEL_W-1:0]  sel;
    logic [WB_DATA_W-1:0] wdata;

    // progress side, driven by the sequencer
    // start marks the edge at which a new access is launched
    logic                 start;
    logic                 rd_done;
    logic                 last_beat;
    logic                 idle;

    modport arb (
        output valid, src, write, qword, exclusive, adr, sel, wdata,
        input  start, rd_done, last_beat, idle
    );

    // the sequencer has no use for the source, only for the access shape
    modport seq (
        input  valid, write, qword, exclusive, adr, sel, wdata,
        output start, rd_done, last_beat, idle
    );

endinterface

/* logic/cache_req_arbiter.sv */
// cache request arbiter with service flags, priority grant, address and select forming
module cache_req_arbiter #(
    parameter int ADDR_W = 32
) (
    input  logic                                i_clk,
    input  logic                                quick_n_reset,

    // instruction cache
    input  logic                                i_icache_req,
    input  logic                                i_icache_qword,
    input  logic [ADDR_W-1:0]                   i_icache_address,
    output logic                                o_icache_ready,

    // data cache
    input  logic                                i_exclusive,
    input  logic                                i_dcache_cached_req,
    input  logic                                i_dcache_uncached_req,
    input  logic                                i_dcache_qword,
    input  logic                                i_dcache_write,
    input  logic [wb_master_pkg::WB_DATA_W-1:0] i_dcache_write_data,
    input  logic [wb_master_pkg::WB_SEL_W-1:0]  i_dcache_byte_enable,
    input  logic [ADDR_W-1:0]                   i_dcache_address,
    output logic                                o_dcache_cached_ready,
    output logic                                o_dcache_uncached_ready,

    wb_req_if.arb                               req
);
    import wb_master_pkg::*;

    // one flag per read source, set while that source owns the bus
    logic       svc_dc_cached;
    logic       svc_dc_uncached;
    logic       svc_icache;

    logic       dc_cached_rd;
    logic       dc_uncached_rd;
    logic       dc_wr;
    logic       ic_rd;
    logic [1:0] be_low;
    logic       wr_ready;

    // ========================================
    // request qualification
    // ========================================

    // a read already in service stays masked so it cannot be granted a second time
    assign dc_cached_rd   = i_dcache_cached_req && !i_dcache_write && !svc_dc_cached;
    assign dc_uncached_rd = i_dcache_uncached_req && !i_dcache_write && !svc_dc_uncached;
    assign dc_wr          = (i_dcache_cached_req || i_dcache_uncached_req) && i_dcache_write;
    assign ic_rd          = i_icache_req && !svc_icache;

    // byte and halfword accesses put their lane number on the low address bits
    always_comb
    begin
        case (i_dcache_byte_enable)
            4'b0001: be_low = 2'd0;
            4'b0010: be_low = 2'd1;
            4'b0100: be_low = 2'd2;
            4'b1000: be_low = 2'd3;
            4'b0011: be_low = 2'd0;
            4'b1100: be_low = 2'd2;
            default: be_low = 2'd0;
        endcase
    end

    // ========================================
    // priority grant
    // ========================================

    // data reads first, then data writes, then the instruction cache
    // within the data cache the cached port is ahead of the uncached one
    always_comb
    begin
        req.src       = SRC_NONE;
        req.write     = 1'b0;
        req.qword     = 1'b0;
        req.exclusive = i_exclusive;
        req.adr       = {i_dcache_address[ADDR_W-1:2], be_low};
        req.sel       = FULL_SEL;
        if (dc_cached_rd)
        begin
            req.src   = SRC_DCACHE_CACHED;
            req.qword = i_dcache_qword;
        end
        else if (dc_uncached_rd)
        begin
            req.src   = SRC_DCACHE_UNCACHED;
            req.qword = i_dcache_qword;
        end
        else if (dc_wr)
        begin
            req.src   = i_dcache_cached_req ? SRC_DCACHE_CACHED : SRC_DCACHE_UNCACHED;
            req.write = 1'b1;
            req.sel   = i_dcache_byte_enable;
        end
        else if (ic_rd)
        begin
            // fetches are always whole aligned words and never lock the bus
            req.src       = SRC_ICACHE;
            req.qword     = i_icache_qword;
            req.exclusive = 1'b0;
            req.adr       = {i_icache_address[ADDR_W-1:2], 2'b00};
        end
    end

    assign req.valid = (req.src != SRC_NONE);
    assign req.wdata = i_dcache_write_data;

    // ========================================
    // ready routing
    // ========================================

    // a posted write is accepted the moment the sequencer takes it
    assign wr_ready = req.start && req.write;

    assign o_dcache_cached_ready   = (svc_dc_cached && req.rd_done) ||
                                     (wr_ready && (req.src == SRC_DCACHE_CACHED));
    assign o_dcache_uncached_ready = (svc_dc_uncached && req.rd_done) ||
                                     (wr_ready && (req.src == SRC_DCACHE_UNCACHED));
    assign o_icache_ready          = svc_icache && req.rd_done;

    // flags drop at the edge of the final ack and are set when a read launches
    // only a write ack can end one access at the edge another one starts
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            svc_dc_cached   <= 1'b0;
            svc_dc_uncached <= 1'b0;
            svc_icache      <= 1'b0;
        end
        else
        begin
            if (req.last_beat)
            begin
                svc_dc_cached   <= 1'b0;
                svc_dc_uncached <= 1'b0;
                svc_icache      <= 1'b0;
            end
            if (req.start && !req.write)
            begin
                svc_dc_cached   <= (req.src == SRC_DCACHE_CACHED);
                svc_dc_uncached <= (req.src == SRC_DCACHE_UNCACHED);
                svc_icache      <= (req.src == SRC_ICACHE);
            end
        end
    end

    // the bus serves one reader at a time
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        $onehot0({svc_dc_cached, svc_dc_uncached, svc_icache}));

    // a ready pulse, whether from a read ack or a posted write, needs its request still up
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (!o_icache_ready || i_icache_req) &&
        (!o_dcache_cached_ready || i_dcache_cached_req) &&
        (!o_dcache_uncached_ready || i_dcache_uncached_req));

endmodule

/* logic/wb_bus_sequencer.sv */
// wishbone cycle FSM with wrapping burst address, write ack tracking and bus lock
module wb_bus_sequencer #(
    parameter int ADDR_W = 32
) (
    input  logic                                i_clk,
    input  logic                                quick_n_reset,

    wb_req_if.seq                               req,

    // wishbone master side
    input  logic [wb_master_pkg::WB_DATA_W-1:0] i_wb_dat,
    input  logic                                i_wb_ack,
    output logic [ADDR_W-1:0]                   o_wb_adr,
    output logic [wb_master_pkg::WB_SEL_W-1:0]  o_wb_sel,
    output logic                                o_wb_we,
    output logic [wb_master_pkg::WB_DATA_W-1:0] o_wb_dat,
    output logic                                o_wb_cyc,
    output logic                                o_wb_stb,

    output logic [wb_master_pkg::WB_DATA_W-1:0] o_rd_data
);
    import wb_master_pkg::*;

    wb_state_e state;

    // exclusive flag of the access on the bus, keeps cyc up once that access ends
    logic      excl_r;
    logic      ack_beat;
    logic      in_burst;
    logic      wr_outstanding;

    // ========================================
    // progress signals
    // ========================================

    assign ack_beat = o_wb_stb && i_wb_ack;
    assign in_burst = (state == WB_BURST1) || (state == WB_BURST2) || (state == WB_BURST3);

    // posted writes keep the FSM in WB_IDLE, so stb with we in idle means a write ack is owed
    assign wr_outstanding = (state == WB_IDLE) && o_wb_stb && o_wb_we;

    // the ack of an outstanding write frees the bus in the same cycle
    assign req.idle      = (state == WB_IDLE) && !(wr_outstanding && !i_wb_ack);
    assign req.start     = req.valid && req.idle;
    assign req.rd_done   = ack_beat && !o_wb_we;
    assign req.last_beat = ack_beat && ((state == WB_WAIT_ACK) || wr_outstanding);

    // both caches sample the bus data during their ready pulse
    assign o_rd_data = i_wb_dat;

    // ========================================
    // control and state
    // ========================================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state    <= WB_IDLE;
            o_wb_stb <= 1'b0;
            o_wb_cyc <= 1'b0;
            o_wb_we  <= 1'b0;
            o_wb_sel <= '0;
            excl_r   <= 1'b0;
        end
        else if (req.start)
        begin
            // a start on a write ack leaves stb high for back to back cycles
            o_wb_stb <= 1'b1;
            o_wb_cyc <= 1'b1;
            o_wb_we  <= req.write;
            o_wb_sel <= req.sel;
            excl_r   <= req.exclusive;
            if (req.write)
                state <= WB_IDLE;
            else if (req.qword)
                state <= WB_BURST1;
            else
                state <= WB_WAIT_ACK;
        end
        else if (req.last_beat)
        begin
            // after a swap read cyc stays up so no other master slips in before the write
            o_wb_stb <= 1'b0;
            o_wb_cyc <= excl_r;
            o_wb_we  <= 1'b0;
            state    <= WB_IDLE;
        end
        else if (ack_beat)
        begin
            case (state)
                WB_BURST1: state <= WB_BURST2;
                WB_BURST2: state <= WB_BURST3;
                WB_BURST3: state <= WB_WAIT_ACK;
                default:   state <= state;
            endcase
        end
    end

    // ========================================
    // address and write data
    // ========================================

    // the line fill wraps inside its 16 byte line, the upper address never moves
    always_ff @(posedge i_clk)
    begin
        if (req.start)
        begin
            o_wb_adr <= req.adr;
            o_wb_dat <= req.wdata;
        end
        else if (ack_beat && in_burst)
        begin
            o_wb_adr[BEAT_W+1:2] <= o_wb_adr[BEAT_W+1:2] + BEAT_W'(1);
        end
    end

    // each burst beat advances on its ack
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state == WB_BURST1) && i_wb_ack |=> (state == WB_BURST2));
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state == WB_BURST2) && i_wb_ack |=> (state == WB_BURST3));
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state == WB_BURST3) && i_wb_ack |=> (state == WB_WAIT_ACK));

    // the last read ack always returns to idle
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state == WB_WAIT_ACK) && i_wb_ack |=> (state == WB_IDLE));

    // idle never jumps into the middle of a burst
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state == WB_IDLE) |=> (state inside {WB_IDLE, WB_BURST1, WB_WAIT_ACK}));

endmodule

/* logic/amber_wb_master.sv */
// top level of the wishbone master joining the request arbiter and the bus sequencer
module amber_wb_master #(
    parameter int ADDR_W = 32
) (
    input  logic                                i_clk,
    input  logic                                quick_n_reset,

    // instruction cache
    input  logic                                i_icache_req,
    input  logic                                i_icache_qword,
    input  logic [ADDR_W-1:0]                   i_icache_address,
    output logic [wb_master_pkg::WB_DATA_W-1:0] o_icache_read_data,
    output logic                                o_icache_ready,

    // data cache, i_exclusive is raised for the read half of a swap
    input  logic                                i_exclusive,
    input  logic                                i_dcache_cached_req,
    input  logic                                i_dcache_uncached_req,
    input  logic                                i_dcache_qword,
    input  logic                                i_dcache_write,
    input  logic [wb_master_pkg::WB_DATA_W-1:0] i_dcache_write_data,
    input  logic [wb_master_pkg::WB_SEL_W-1:0]  i_dcache_byte_enable,
    input  logic [ADDR_W-1:0]                   i_dcache_address,
    output logic [wb_master_pkg::WB_DATA_W-1:0] o_dcache_read_data,
    output logic                                o_dcache_cached_ready,
    output logic                                o_dcache_uncached_ready,

    // wishbone bus
    output logic [ADDR_W-1:0]                   o_wb_adr,
    output logic [wb_master_pkg::WB_SEL_W-1:0]  o_wb_sel,
    output logic                                o_wb_we,
    input  logic [wb_master_pkg::WB_DATA_W-1:0] i_wb_dat,
    output logic [wb_master_pkg::WB_DATA_W-1:0] o_wb_dat,
    output logic                                o_wb_cyc,
    output logic                                o_wb_stb,
    input  logic                                i_wb_ack
);
    import wb_master_pkg::*;

    logic [WB_DATA_W-1:0] rd_data;

    wb_req_if #(.ADDR_W(ADDR_W)) u_req_if ();

    cache_req_arbiter #(.ADDR_W(ADDR_W)) u_cache_req_arbiter (
        .i_clk                   (i_clk),
        .quick_n_reset           (quick_n_reset),
        .i_icache_req            (i_icache_req),
        .i_icache_qword          (i_icache_qword),
        .i_icache_address        (i_icache_address),
        .o_icache_ready          (o_icache_ready),
        .i_exclusive             (i_exclusive),
        .i_dcache_cached_req     (i_dcache_cached_req),
        .i_dcache_uncached_req   (i_dcache_uncached_req),
        .i_dcache_qword          (i_dcache_qword),
        .i_dcache_write          (i_dcache_write),
        .i_dcache_write_data     (i_dcache_write_data),
        .i_dcache_byte_enable    (i_dcache_byte_enable),
        .i_dcache_address        (i_dcache_address),
        .o_dcache_cached_ready   (o_dcache_cached_ready),
        .o_dcache_uncached_ready (o_dcache_uncached_ready),
        .req                     (u_req_if.arb)
    );

    wb_bus_sequencer #(.ADDR_W(ADDR_W)) u_wb_bus_sequencer (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .req           (u_req_if.seq),
        .i_wb_dat      (i_wb_dat),
        .i_wb_ack      (i_wb_ack),
        .o_wb_adr      (o_wb_adr),
        .o_wb_sel      (o_wb_sel),
        .o_wb_we       (o_wb_we),
        .o_wb_dat      (o_wb_dat),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb),
        .o_rd_data     (rd_data)
    );

    // both caches see the same bus data and tell their beats apart by their ready
    assign o_icache_read_data = rd_data;
    assign o_dcache_read_data = rd_data;

endmodule

/* bench/wb_slave_model.sv */
// wishbone memory slave with random ack wait states and byte lane merging on writes
module wb_slave_model #(
    parameter int          ADDR_W = 32,
    parameter logic [31:0] SEED   = 32'hb5a8
) (
    input  logic                                i_clk,
    input  logic                                quick_n_reset,
    input  logic [ADDR_W-1:0]                   i_adr,
    input  logic [wb_master_pkg::WB_SEL_W-1:0]  i_sel,
    input  logic                                i_we,
    input  logic [wb_master_pkg::WB_DATA_W-1:0] i_dat,
    input  logic                                i_cyc,
    input  logic                                i_stb,
    output logic [wb_master_pkg::WB_DATA_W-1:0] o_dat,
    output logic                                o_ack
);
    import wb_master_pkg::*;

    // 64 words, so only address bits [7:2] select a word
    localparam int MEM_WORDS = 64;
    localparam int IDX_W     = $clog2(MEM_WORDS);

    logic [WB_DATA_W-1:0] mem [MEM_WORDS];
    logic [31:0]          rand_state;
    logic                 waiting;
    logic [1:0]           wait_left;
    logic [IDX_W-1:0]     idx;

    // this LCG runs apart from the requester stimulus so wait states do not track it
    function automatic logic [31:0] advance_lcg(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    assign idx = i_adr[IDX_W+1:2];

    // every bit of the fill word depends on the full word index
    initial
    begin
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = (i + 1) * 32'h9e37_79b9;
    end

    // ========================================
    // ack timing and memory access
    // ========================================

    // first sight of stb draws 0 to 3 wait cycles, the beat completes when they run out
    always @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            o_ack      <= 1'b0;
            o_dat      <= '0;
            waiting    <= 1'b0;
            wait_left  <= 2'd0;
            rand_state <= SEED;
        end
        else
        begin
            o_ack <= 1'b0;
            // the cycle that carries an ack is never counted as a new request
            if (i_cyc && i_stb && !o_ack)
            begin
                if (!waiting)
                begin
                    rand_state <= advance_lcg(rand_state);
                    wait_left  <= rand_state[17:16];
                    waiting    <= 1'b1;
                end
                else if (wait_left != 2'd0)
                    wait_left <= wait_left - 2'd1;
                else
                begin
                    o_ack   <= 1'b1;
                    waiting <= 1'b0;
                    if (i_we)
                    begin
                        for (int b = 0; b < WB_SEL_W; b++)
                            if (i_sel[b])
                                mem[idx][8*b +: 8] <= i_dat[8*b +: 8];
                    end
                    else
                        o_dat <= mem[idx];
                end
            end
        end
    end

endmodule

/* bench/amber_wb_master_tb.sv */
// testbench for the wishbone master with random cache requesters, memory slave and reference memory
module amber_wb_master_tb;
    import wb_master_pkg::*;

    localparam int ADDR_W       = 32;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 200;
    localparam int N_RACE       = 8;
    // every random access has a read back, every race has two reads
    localparam int N_ACCESSES   = 2 * N_RANDOM + 2 * N_RACE;
    localparam int TIME_LIMIT   = N_ACCESSES * 4 * 8 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    // requester codes of the stimulus
    localparam int DC_CACHED   = 0;
    localparam int DC_UNCACHED = 1;
    localparam int ICACHE      = 2;

    logic i_clk, quick_n_reset;
    logic icache_req, icache_qword, icache_ready;
    logic exclusive, dcache_cached_req, dcache_uncached_req, dcache_qword, dcache_write;
    logic dcache_cached_ready, dcache_uncached_ready;
    logic wb_we, wb_cyc, wb_stb, wb_ack;
    logic [ADDR_W-1:0]    icache_address, dcache_address, wb_adr;
    logic [WB_SEL_W-1:0]  dcache_byte_enable, wb_sel;
    logic [WB_DATA_W-1:0] icache_read_data, dcache_read_data, dcache_write_data;
    logic [WB_DATA_W-1:0] wb_dat_rd, wb_dat_wr;
    logic [WB_DATA_W-1:0] ref_mem [64];
    logic [31:0]          seed;
    int                   fail_count;

    amber_wb_master #(.ADDR_W(ADDR_W)) u_amber_wb_master (
        .i_clk(i_clk), .quick_n_reset(quick_n_reset),
        .i_icache_req(icache_req), .i_icache_qword(icache_qword),
        .i_icache_address(icache_address), .o_icache_read_data(icache_read_data),
        .o_icache_ready(icache_ready), .i_exclusive(exclusive),
        .i_dcache_cached_req(dcache_cached_req), .i_dcache_uncached_req(dcache_uncached_req),
        .i_dcache_qword(dcache_qword), .i_dcache_write(dcache_write),
        .i_dcache_write_data(dcache_write_data), .i_dcache_byte_enable(dcache_byte_enable),
        .i_dcache_address(dcache_address), .o_dcache_read_data(dcache_read_data),
        .o_dcache_cached_ready(dcache_cached_ready),
        .o_dcache_uncached_ready(dcache_uncached_ready),
        .o_wb_adr(wb_adr), .o_wb_sel(wb_sel), .o_wb_we(wb_we), .i_wb_dat(wb_dat_rd),
        .o_wb_dat(wb_dat_wr), .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .i_wb_ack(wb_ack)
    );

    wb_slave_model #(.ADDR_W(ADDR_W)) u_wb_slave_model (
        .i_clk(i_clk), .quick_n_reset(quick_n_reset), .i_adr(wb_adr), .i_sel(wb_sel),
        .i_we(wb_we), .i_dat(wb_dat_wr), .i_cyc(wb_cyc), .i_stb(wb_stb),
        .o_dat(wb_dat_rd), .o_ack(wb_ack)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // the run is bounded by the worst beat count of every access
    initial
    begin
        #(TIME_LIMIT);
        $display("Error: the run did not finish within %0d time units", TIME_LIMIT);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    // ========================================
    // helpers
    // ========================================

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        fail_count++;
        $display("** Error: %s = %h, expected %h at time %0t", name, got, expected, $time);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_problem(input string what);
        fail_count++;
        $display("Error: %s at time %0t", what, $time);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // byte lane of a byte or halfword access, everything else is word aligned
    function automatic logic [1:0] low_bits_for(input logic [3:0] be);
        case (be)
            4'b0010: return 2'd1;
            4'b0100: return 2'd2;
            4'b1000: return 2'd3;
            4'b1100: return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

    function automatic logic [3:0] be_pattern(input logic [2:0] pick);
        logic [3:0] table_be [8];
        table_be = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111, 4'b0110};
        return table_be[pick];
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word, input logic [3:0] be);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++)
            if (be[b])
                merged[8*b +: 8] = new_word[8*b +: 8];
        return merged;
    endfunction

    task automatic check_bus_quiet();
        assert ({wb_stb, wb_cyc, wb_we} == 3'b000)
        else report_mismatch("{o_wb_stb,o_wb_cyc,o_wb_we}", {wb_stb, wb_cyc, wb_we}, 0);
        assert ({icache_ready, dcache_cached_ready, dcache_uncached_ready} == 3'b000)
        else report_mismatch("{o_icache_ready,o_dcache_cached_ready,o_dcache_uncached_ready}",
                             {icache_ready, dcache_cached_ready, dcache_uncached_ready}, 0);
    endtask

    // ========================================
    // one requester access
    // ========================================

    // requests go up on a falling edge and are sampled just before each rising edge
    task automatic run_access(input int src, input logic write, input logic qword,
                              input logic excl, input logic [ADDR_W-1:0] addr,
                              input logic [31:0] data, input logic [3:0] be);
        int          beats;
        int          beat;
        logic        mine;
        logic [2:0]  readies;
        logic [2:0]  mine_mask;
        logic [5:0]  word;
        logic [1:0]  low;
        logic [31:0] rd;
        beats     = (!write && qword) ? BURST_BEATS : 1;
        beat      = 0;
        low       = (src == ICACHE) ? 2'd0 : low_bits_for(be);
        mine_mask = (src == ICACHE) ? 3'b100 : (src == DC_CACHED) ? 3'b010 : 3'b001;
        @(negedge i_clk);
        icache_req          = (src == ICACHE);
        icache_qword        = qword;
        icache_address      = addr;
        dcache_cached_req   = (src == DC_CACHED);
        dcache_uncached_req = (src == DC_UNCACHED);
        dcache_write        = write;
        dcache_qword        = qword;
        exclusive           = excl;
        dcache_address      = addr;
        dcache_write_data   = data;
        dcache_byte_enable  = be;
        while (beat < beats)
        begin
            @(posedge i_clk);
            readies = {icache_ready, dcache_cached_ready, dcache_uncached_ready};
            mine    = |(readies & mine_mask);
            assert ((readies & ~mine_mask) == 3'b000)
            else report_problem("a ready pulsed on a cache that is not being served");
            if (mine)
            begin
                // burst beats walk the word index inside the 16 byte line
                word = {addr[7:4], addr[3:2] + 2'(beat)};
                rd   = (src == ICACHE) ? icache_read_data : dcache_read_data;
                if (write)
                    ref_mem[word] = merge_bytes(ref_mem[word], data, be);
                else
                begin
                    assert (wb_adr[3:2] == word[1:0])
                    else report_mismatch("o_wb_adr[3:2]", wb_adr[3:2], word[1:0]);
                    assert (wb_adr[1:0] == low)
                    else report_mismatch("o_wb_adr[1:0]", wb_adr[1:0], low);
                    assert (wb_sel == FULL_SEL)
                    else report_mismatch("o_wb_sel", wb_sel, FULL_SEL);
                    assert (rd == ref_mem[word])
                    else report_mismatch("read data", rd, ref_mem[word]);
                end
                beat++;
            end
        end
        @(negedge i_clk);
        icache_req          = 1'b0;
        dcache_cached_req   = 1'b0;
        dcache_uncached_req = 1'b0;
        exclusive           = 1'b0;
        if (write)
        begin
            assert (wb_stb && wb_we)
            else report_problem("a posted write did not raise stb and we");
            assert (wb_adr == {addr[ADDR_W-1:2], low})
            else report_mismatch("o_wb_adr", wb_adr, {addr[ADDR_W-1:2], low});
            assert (wb_sel == be)
            else report_mismatch("o_wb_sel", wb_sel, be);
            assert (wb_dat_wr == data)
            else report_mismatch("o_wb_dat", wb_dat_wr, data);
        end
        else
        begin
            // a swap read keeps the bus locked with no strobe
            assert (!wb_stb)
            else report_problem("stb stayed high after the last read beat");
            assert (wb_cyc == excl)
            else report_mismatch("o_wb_cyc", wb_cyc, excl);
        end
    endtask

    // both caches ask in the same cycle and the data cache must reach the bus first
    task automatic run_race(input logic [ADDR_W-1:0] iaddr, input logic [ADDR_W-1:0] daddr);
        logic i_done, d_done, stb_seen;
        i_done   = 1'b0;
        d_done   = 1'b0;
        stb_seen = 1'b0;
        @(negedge i_clk);
        icache_req         = 1'b1;
        icache_qword       = 1'b0;
        icache_address     = iaddr;
        dcache_cached_req  = 1'b1;
        dcache_write       = 1'b0;
        dcache_qword       = 1'b0;
        dcache_address     = daddr;
        dcache_byte_enable = 4'b1111;
        while (!(i_done && d_done))
        begin
            @(posedge i_clk);
            if (wb_stb && !stb_seen)
            begin
                stb_seen = 1'b1;
                assert (wb_adr == daddr)
                else report_mismatch("o_wb_adr", wb_adr, daddr);
            end
            if (icache_ready)
            begin
                assert (icache_read_data == ref_mem[iaddr[7:2]])
                else report_mismatch("o_icache_read_data", icache_read_data, ref_mem[iaddr[7:2]]);
                i_done = 1'b1;
            end
            if (dcache_cached_ready)
            begin
                assert (dcache_read_data == ref_mem[daddr[7:2]])
                else report_mismatch("o_dcache_read_data", dcache_read_data, ref_mem[daddr[7:2]]);
                d_done = 1'b1;
            end
            @(negedge i_clk);
            if (i_done)
                icache_req = 1'b0;
            if (d_done)
                dcache_cached_req = 1'b0;
        end
    endtask

    // ========================================
    // main sequence
    // ========================================

    initial
    begin
        logic [31:0] pick, addr_draw;
        int          src;
        logic        write, qword, excl;
        quick_n_reset       = 1'b0;
        icache_req          = 1'b0;
        icache_qword        = 1'b0;
        icache_address      = '0;
        exclusive           = 1'b0;
        dcache_cached_req   = 1'b0;
        dcache_uncached_req = 1'b0;
        dcache_qword        = 1'b0;
        dcache_write        = 1'b0;
        dcache_write_data   = '0;
        dcache_byte_enable  = '0;
        dcache_address      = '0;
        seed                = 32'hb5a8;
        fail_count          = 0;
        repeat (RESET_CYCLES)
        begin
            @(negedge i_clk);
            check_bus_quiet();
        end
        quick_n_reset = 1'b1;
        @(negedge i_clk);
        check_bus_quiet();
        // the slave fill is the starting point of the reference memory
        for (int i = 0; i < 64; i++)
            ref_mem[i] = u_wb_slave_model.mem[i];
        for (int n = 0; n < N_RANDOM; n++)
        begin
            pick      = next_random();
            addr_draw = next_random();
            src       = int'(pick[31:28]) % 3;
            write     = (src != ICACHE) && pick[27];
            qword     = !write && pick[26];
            excl      = (src != ICACHE) && (pick[25:24] == 2'b00);
            run_access(src, write, qword, excl, {24'h0, addr_draw[23:16]}, next_random(),
                       be_pattern(pick[23:21]));
            run_access(src, 1'b0, 1'b0, 1'b0, {24'h0, addr_draw[23:16]}, 32'h0,
                       be_pattern(pick[23:21]));
        end
        for (int n = 0; n < N_RACE; n++)
        begin
            pick = next_random();
            run_race({24'h0, pick[31:26], 2'b00}, {24'h0, pick[23:18], 2'b00});
        end
        if (fail_count == 0)
        begin
            $display("All tests passed!");
            $finish;
        end
        else
        begin
            $display("Test failures found");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* amber_wb_master.f */
logic/wb_master_pkg.sv
logic/wb_req_if.sv
logic/cache_req_arbiter.sv
logic/wb_bus_sequencer.sv
logic/amber_wb_master.sv
bench/wb_slave_model.sv
bench/amber_wb_master_tb.sv

/* Bender.yml */
package:
  name: amber_wb_master

sources:
  - files:
      - logic/wb_master_pkg.sv
      - logic/wb_req_if.sv
      - logic/cache_req_arbiter.sv
      - logic/wb_bus_sequencer.sv
      - logic/amber_wb_master.sv
  - target: test
    files:
      - bench/wb_slave_model.sv
      - bench/amber_wb_master_tb.sv
